// File: verification/datapathCases.txt
# name  control (hex, bit map in datapathTb)  InPortdata  expected OutPortdata  flags
# flags: bit 0 checks OutPortdata, bit 1 drives InPortdata (otherwise random)
reset         000000000 000001A5 00000000 3
memMar        000010080 02118000 00000000 2
memMdr        000020080 00000000 00000000 0
memWrite      000400000 00000000 00000000 0
memClear      000020000 00000000 00000000 0
memRead       000320000 00000000 00000000 0
memRoundTrip  0000C0040 92345678 02118000 3
inR4          000000092 00000000 00000000 0
outR4         000000043 0F0F0F04 92345678 3
inR2          000000094 00000000 00000000 0
loadY         000008003 00000000 00000000 0
addCalc       001001005 00000000 00000000 0
add           000000858 00000000 A143657C 1
subCalc       002001005 00000000 00000000 0
sub           000000858 00000000 83254774 1
andCalc       004001005 00000000 00000000 0
and           000000858 00000000 02040600 1
orCalc        008001005 00000000 00000000 0
or            000000858 00000000 9F3F5F7C 1
shlCalc       010001005 00000000 00000000 0
shl           000000858 00000000 23456780 1
shrCalc       020001005 00000000 00000000 0
shr           000000858 00000000 09234567 1
shraCalc      040001005 00000000 00000000 0
shra          000000858 00000000 F9234567 1
rolCalc       080001005 00000000 00000000 0
rol           000000858 00000000 23456789 1
rorCalc       100001005 00000000 00000000 0
ror           000000858 00000000 89234567 1
negCalc       200001005 00000000 00000000 0
neg           000000858 00000000 F0F0F0FC 1
notCalc       400001005 00000000 00000000 0
not           000000858 00000000 F0F0F0FB 1
pcInc1        000001500 00000000 00000000 0
pcLoad1       000000A00 00000000 00000000 0
pcInc2        000001500 00000000 00000000 0
pcLoad2       000000A00 00000000 00000000 0
pcToR3        000000118 00000000 00000000 0
pcOut         000000049 00000000 00000002 1
irClear       000080000 00000000 00000000 0
r0Write       000000812 00000000 00000000 0
baseZero      000000062 00000000 00000000 1
end           000000000 00000000 00000000 0

// File: vlog.f
design/datapathPkg.sv
design/regFile.sv
design/aluUnit.sv
design/memInterface.sv
design/instrDecode.sv
design/ioPorts.sv
design/datapath.sv
verification/datapathTb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = datapathTb
FILELIST = vlog.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) > $(LOG) 2>&1
	./obj_dir/V$(TOP) >> $(LOG) 2>&1
	@cat $(LOG)
	@! grep -q "sim failed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: verification/datapathTb.sv
`timescale 1ns/1ps

module datapathTb;
	import datapathPkg::*;

	// Polls are 1 ns apart, so this bounds each edge wait in ns
	localparam int edgeTimeout = 40;
	localparam int resetCycles = 8;

	logic clock;
	logic arstN;
	// Control word, bit order fixed by the port map below
	logic [35:0] ctrl;
	logic [dataWidth-1:0] InPortdata;
	logic [dataWidth-1:0] OutPortdata;
	int riseCount = 0;
	int fallCount = 0;
	int mismatches = 0;
	int failures = 0;
	int checks = 0;
	// Set once an edge wait runs out, later waits return at once
	bit timedOut = 1'b0;

	datapath dut_i (
		.clock, .arstN,
		.Rout(ctrl[0]), .Gra(ctrl[1]), .Grb(ctrl[2]), .Grc(ctrl[3]),
		.Rin(ctrl[4]), .BAout(ctrl[5]), .OutPortin(ctrl[6]), .InPortout(ctrl[7]),
		.PCout(ctrl[8]), .PCin(ctrl[9]), .IncPC(ctrl[10]), .Zlowout(ctrl[11]),
		.Zlowin(ctrl[12]), .Zhighin(ctrl[13]), .Zhighout(ctrl[14]), .Yin(ctrl[15]),
		.MARin(ctrl[16]), .MDRin(ctrl[17]), .MDRout(ctrl[18]), .IRin(ctrl[19]),
		.MDMuxread(ctrl[20]), .RAMread(ctrl[21]), .RAMwrite(ctrl[22]),
		.ADD(ctrl[24]), .SUB(ctrl[25]), .AND(ctrl[26]), .OR(ctrl[27]),
		.SHL(ctrl[28]), .SHR(ctrl[29]), .SHRA(ctrl[30]), .ROL(ctrl[31]),
		.ROR(ctrl[32]), .NEG(ctrl[33]), .NOT(ctrl[34]),
		.InPortdata, .OutPortdata
	);

	// 8 ns clock
	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	// Edge counters the wait loops poll
	always @(posedge clock) riseCount <= riseCount + 1;
	always @(negedge clock) fallCount <= fallCount + 1;

	task automatic endRun();
		$display("Errors: %0d mismatches, %0d other failures in %0d checks",
			mismatches, failures, checks);
		if (mismatches == 0 && failures == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	endtask

	// Polls land half a ns past the edges, never on them
	task automatic waitEdge(input bit rising);
		int start;
		int polls;
		start = rising ? riseCount : fallCount;
		polls = 0;
		while (!timedOut && (rising ? riseCount : fallCount) == start) begin
			if (polls == edgeTimeout) begin
				timedOut = 1'b1;
				failures++;
				$display("Timeout: clock edge did not arrive within %0d ns", edgeTimeout);
			end else begin
				#1;
				polls++;
			end
		end
	endtask

	// One clock step; a checked step is followed by an idle step
	task automatic applyStep(input string name, input logic [35:0] ctrlIn,
		input logic [dataWidth-1:0] portIn, input logic [dataWidth-1:0] expected,
		input logic [3:0] flags);
		waitEdge(1'b0);
		ctrl = ctrlIn;
		if (flags[1]) InPortdata = portIn;
		else InPortdata = $urandom;
		if (flags[0]) begin
			waitEdge(1'b1);
			waitEdge(1'b0);
			// Strobes off so the transfer is not repeated
			ctrl = '0;
			waitEdge(1'b1);
			if (!timedOut) begin
				checks++;
				if (OutPortdata !== expected) begin
					mismatches++;
					$display("Mismatch in %s: expected %08h, actual %08h", name, expected,
						OutPortdata);
				end
			end
		end
	endtask

	initial begin
		int fd;
		int fields;
		int lineNo;
		bit sawEnd;
		string line;
		string name;
		logic [35:0] ctrlIn;
		logic [dataWidth-1:0] portIn;
		logic [dataWidth-1:0] expected;
		logic [3:0] flags;

		ctrl = '0;
		InPortdata = '0;
		arstN = 1'b0;
		lineNo = 0;
		sawEnd = 1'b0;
		void'($urandom(38610));
		// Offset from the clock edges
		#0.5;
		repeat (resetCycles) waitEdge(1'b1);
		waitEdge(1'b0);
		arstN = 1'b1;

		if (!timedOut) begin
			fd = $fopen("verification/datapathCases.txt", "r");
			if (fd == 0) begin
				failures++;
				$display("Could not open verification/datapathCases.txt");
			end else begin
				while (!sawEnd && !timedOut && $fgets(line, fd) > 0) begin
					lineNo++;
					// Comments and blank lines
					if (line[0] == "#" || line[0] == "\n") continue;
					fields = $sscanf(line, "%s %h %h %h %h",
						name, ctrlIn, portIn, expected, flags);
					if (fields != 5) begin
						failures++;
						$display("Line %0d of the cases file has %0d fields instead of 5",
							lineNo, fields);
					end else if (name == "end") begin
						sawEnd = 1'b1;
					end else begin
						applyStep(name, ctrlIn, portIn, expected, flags);
					end
				end
				$fclose(fd);
				if (!sawEnd && !timedOut) begin
					failures++;
					$display("Cases file ended before its end line, %0d lines read", lineNo);
				end
			end
		end
		endRun();
	end

endmodule

// File: design/datapath.sv
`timescale 1ns/1ps

module datapath (
	input  logic clock,
	input  logic arstN,
	// Bus out-strobes
	input  logic PCout, Zlowout, Zhighout, MDRout, InPortout, Rout, BAout,
	// Register in-strobes
	input  logic PCin, MARin, MDRin, IRin, Yin, Rin, OutPortin, Zlowin, Zhighin,
	// Memory and register select
	input  logic MDMuxread, RAMread, RAMwrite, Gra, Grb, Grc,
	// ALU strobes
	input  logic ADD, SUB, AND, OR, SHL, SHR, SHRA, ROL, ROR, NEG, NOT, IncPC,
	input  logic [datapathPkg::dataWidth-1:0] InPortdata,
	output logic [datapathPkg::dataWidth-1:0] OutPortdata
);
	import datapathPkg::*;

	logic [dataWidth-1:0] busData;
	logic [dataWidth-1:0] pcReg;
	logic [dataWidth-1:0] regData, zLow, zHigh, mdrData, inPortData;
	logic [regSelWidth-1:0] regSel;
	// BAout also drives the register word, R0 then reads zero
	logic regOut;
	aluOp op;

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) pcReg <= '0;
		else if (PCin) pcReg <= busData;
	end

	assign regOut = Rout || BAout;

	// AND-OR bus mux, zero when nothing drives
	assign busData = ({dataWidth{PCout}} & pcReg)
		| ({dataWidth{Zlowout}} & zLow)
		| ({dataWidth{Zhighout}} & zHigh)
		| ({dataWidth{MDRout}} & mdrData)
		| ({dataWidth{InPortout}} & inPortData)
		| ({dataWidth{regOut}} & regData);

	// One-hot strobes to ALU op
	always_comb begin
		if (ADD) op = aluAdd;
		else if (SUB) op = aluSub;
		else if (AND) op = aluAnd;
		else if (OR) op = aluOr;
		else if (SHL) op = aluShl;
		else if (SHR) op = aluShr;
		else if (SHRA) op = aluShra;
		else if (ROL) op = aluRol;
		else if (ROR) op = aluRor;
		else if (NEG) op = aluNeg;
		else if (NOT) op = aluNot;
		else if (IncPC) op = aluInc;
		else op = aluNone;
	end

	regFile regFile_i (.clock, .arstN, .Rin, .BAout, .regSel, .busData, .regData);
	aluUnit aluUnit_i (.clock, .arstN, .Yin, .Zlowin, .Zhighin, .op, .busData, .zLow, .zHigh);
	memInterface memInterface_i (.clock, .arstN, .MARin, .MDRin, .MDMuxread, .RAMread,
		.RAMwrite, .busData, .mdrData);
	instrDecode instrDecode_i (.clock, .arstN, .IRin, .Gra, .Grb, .Grc, .busData, .regSel);
	ioPorts ioPorts_i (.clock, .arstN, .OutPortin, .InPortdata, .busData, .inPortData,
		.OutPortdata);

	// Single bus driver per step
	busOneHot: assert property (@(posedge clock) disable iff (!arstN)
		$onehot0({PCout, Zlowout, Zhighout, MDRout, InPortout, regOut})
	) else $error("More than one bus source active");

	aluOneHot: assert property (@(posedge clock) disable iff (!arstN)
		$onehot0({ADD, SUB, AND, OR, SHL, SHR, SHRA, ROL, ROR, NEG, NOT, IncPC})
	) else $error("More than one ALU strobe active");

endmodule

// File: design/ioPorts.sv
`timescale 1ns/1ps

module ioPorts (
	input  logic                             clock,
	input  logic                             arstN,
	input  logic                             OutPortin,
	input  logic [datapathPkg::dataWidth-1:0] InPortdata,
	input  logic [datapathPkg::dataWidth-1:0] busData,
	output logic [datapathPkg::dataWidth-1:0] inPortData,
	output logic [datapathPkg::dataWidth-1:0] OutPortdata
);
	import datapathPkg::*;

	// Input sampled every edge, so the bus sees last step's pin value
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			inPortData <= '0;
		end else begin
			inPortData <= InPortdata;
		end
	end

	// Output port holds until the next OutPortin
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) OutPortdata <= {dataWidth{1'b0}};
		else if (OutPortin) OutPortdata <= busData;
	end

endmodule

// File: design/instrDecode.sv
`timescale 1ns/1ps

module instrDecode (
	input  logic                                clock,
	input  logic                                arstN,
	input  logic                                IRin,
	input  logic                                Gra,
	input  logic                                Grb,
	input  logic                                Grc,
	input  logic [datapathPkg::dataWidth-1:0]    busData,
	output logic [datapathPkg::regSelWidth-1:0] regSel
);
	import datapathPkg::*;

	// Instruction register, loaded from the bus
	logic [dataWidth-1:0] irReg;

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			irReg <= '0;
		end else if (IRin) begin
			irReg <= busData;
		end
	end

	// Field pick, ra wins over rb, rb over rc
	always_comb begin
		if (Gra) regSel = irReg[raLsb +: regSelWidth];
		else if (Grb) regSel = irReg[rbLsb +: regSelWidth];
		else if (Grc) regSel = irReg[rcLsb +: regSelWidth];
		else regSel = '0;
	end

	gSelOneHot: assert property (
		@(posedge clock) disable iff (!arstN)
		$onehot0({Gra, Grb, Grc})
	) else $error("More than one of Gra, Grb, Grc high");

endmodule

// File: design/memInterface.sv
`timescale 1ns/1ps

module memInterface (
	input  logic                             clock,
	input  logic                             arstN,
	input  logic                             MARin,
	input  logic                             MDRin,
	input  logic                             MDMuxread,
	input  logic                             RAMread,
	input  logic                             RAMwrite,
	input  logic [datapathPkg::dataWidth-1:0] busData,
	output logic [datapathPkg::dataWidth-1:0] mdrData
);
	import datapathPkg::*;

	logic [dataWidth-1:0] marReg;
	// Word-wide RAM, contents loaded at run time through the MDR
	logic [dataWidth-1:0] mem [ramDepth];
	logic [ramAddrWidth-1:0] ramAddr;
	logic [dataWidth-1:0] ramData;
	// MDR input mux select
	logic memSel;

	// Only the low MAR bits reach the RAM
	assign ramAddr = marReg[ramAddrWidth-1:0];

	// Asynchronous read at MAR
	assign ramData = mem[ramAddr];

	// RAMread qualifies the memory side of the mux
	assign memSel = MDMuxread && RAMread;

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			marReg <= '0;
		end else if (MARin) begin
			marReg <= busData;
		end
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			mdrData <= '0;
		end else if (MDRin) begin
			mdrData <= memSel ? ramData : busData;
		end
	end

	// Write port, MDR into mem[MAR]
	always_ff @(posedge clock) begin
		if (RAMwrite) begin
			mem[ramAddr] <= mdrData;
		end
	end

	ramReadWriteExclusive: assert property (
		@(posedge clock) disable iff (!arstN)
		!(RAMread && RAMwrite)
	) else $error("RAMread and RAMwrite high in the same cycle");

endmodule

// File: design/aluUnit.sv
`timescale 1ns/1ps

module aluUnit (
	input  logic                             clock,
	input  logic                             arstN,
	input  logic                             Yin,
	input  logic                             Zlowin,
	input  logic                             Zhighin,
	input  datapathPkg::aluOp                op,
	input  logic [datapathPkg::dataWidth-1:0] busData,
	output logic [datapathPkg::dataWidth-1:0] zLow,
	output logic [datapathPkg::dataWidth-1:0] zHigh
);
	import datapathPkg::*;

	localparam int shamtWidth = $clog2(dataWidth);

	// First operand, held from an earlier step
	logic [dataWidth-1:0] yReg;
	// Wide result register, low and high halves
	logic [2*dataWidth-1:0] zReg;
	logic [dataWidth-1:0] result;
	logic [shamtWidth-1:0] shamt;
	logic [2*dataWidth-1:0] rolWide;
	logic [2*dataWidth-1:0] rorWide;

	// Shift and rotate amount from the bus
	assign shamt = busData[shamtWidth-1:0];

	// Doubled word so a plain shift gives the rotation
	assign rolWide = {yReg, yReg} << shamt;
	assign rorWide = {yReg, yReg} >> shamt;

	always_comb begin
		case (op)
			aluAdd:  result = yReg + busData;
			aluSub:  result = yReg - busData;
			aluAnd:  result = yReg & busData;
			aluOr:   result = yReg | busData;
			aluShl:  result = yReg << shamt;
			aluShr:  result = yReg >> shamt;
			aluShra: result = $signed(yReg) >>> shamt;
			aluRol:  result = rolWide[2*dataWidth-1:dataWidth];
			aluRor:  result = rorWide[dataWidth-1:0];
			// Unary ops act on the bus, not on Y
			aluNeg:  result = -busData;
			aluNot:  result = ~busData;
			aluInc:  result = busData + 1'b1;
			default: result = busData;
		endcase
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			yReg <= '0;
		end else if (Yin) begin
			yReg <= busData;
		end
	end

	// High half is the sign extension for every kept op
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			zReg <= '0;
		end else if (Zlowin || Zhighin) begin
			zReg <= {{dataWidth{result[dataWidth-1]}}, result};
		end
	end

	assign zLow = zReg[dataWidth-1:0];
	assign zHigh = zReg[2*dataWidth-1:dataWidth];

	// Z only loads under a defined ALU op
	zLoadOpDefined: assert property (
		@(posedge clock) disable iff (!arstN)
		(Zlowin || Zhighin) |-> (op <= aluInc)
	) else $error("Z loaded with an undefined ALU op");

endmodule

// File: design/regFile.sv
`timescale 1ns/1ps

module regFile (
	input  logic                               clock,
	input  logic                               arstN,
	input  logic                               Rin,
	input  logic                               BAout,
	input  logic [datapathPkg::regSelWidth-1:0] regSel,
	input  logic [datapathPkg::dataWidth-1:0]   busData,
	output logic [datapathPkg::dataWidth-1:0]   regData
);
	import datapathPkg::*;

	// R0 to R15
	logic [dataWidth-1:0] regs [regCount];
	// Base-address mode on R0
	logic baseZero;

	// Single write port at regSel
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < regCount; i++) begin
				regs[i] <= '0;
			end
		end else if (Rin) begin
			regs[regSel] <= busData;
		end
	end

	assign baseZero = BAout && (regSel == '0);

	// Read port, R0 reads as zero for base addressing
	assign regData = baseZero ? '0 : regs[regSel];

	// A write and a base-address read cannot share a step
	rinBaoutExclusive: assert property (
		@(posedge clock) disable iff (!arstN)
		!(Rin && BAout)
	) else $error("Rin and BAout high in the same cycle");

endmodule

// File: design/datapathPkg.sv
package datapathPkg;

	// Bus and register width
	localparam int dataWidth = 32;

	// General register file size
	localparam int regCount = 16;
	localparam int regSelWidth = 4;

	// Internal RAM, addressed by the low MAR bits
	localparam int ramDepth = 512;
	localparam int ramAddrWidth = 9;

	// Register fields in the instruction word
	// Opcode sits above ra, each field is regSelWidth wide
	localparam int raLsb = 23;
	localparam int rbLsb = 19;
	localparam int rcLsb = 15;

	// ALU operation, one per ALU strobe
	// aluNone passes the bus straight to Z
	typedef enum logic [3:0] {
		aluNone,
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluShl,
		aluShr,
		aluShra,
		aluRol,
		aluRor,
		aluNeg,
		aluNot,
		aluInc
	} aluOp;

endpackage
